/* hwpf_pkg.sv */
package hwpf_pkg;

  // configuration and address word
  typedef logic [63:0] word_t;

  // 64-byte cache lines
  localparam int LINE_OFFSET_W = 6;
  localparam int LINE_W        = $bits(word_t) - LINE_OFFSET_W;

  typedef logic [LINE_W-1:0] line_t;  // address without byte offset

  // snoop channels for load, store and cmo
  localparam int NR_SNOOP_PORTS = 3;

  // status word holds busy bits in its low half and enable bits in its high half
  localparam int MAX_ENGINES = 32;

  // base word layout with the line address in bits 63..6
  localparam int BASE_EN_BIT    = 0;
  localparam int BASE_REARM_BIT = 1;

  // parameter word layout
  localparam int STRIDE_LSB = 0;
  localparam int STRIDE_W   = 16;  // stride in lines
  localparam int NLINES_LSB = 16;
  localparam int NLINES_W   = 8;   // number of lines to fetch

  // cache maintenance operations
  typedef enum logic [2:0] {
    CMO_PREFETCH = 3'd0,
    CMO_INVAL    = 3'd1,
    CMO_FLUSH    = 3'd2,
    CMO_CLEAN    = 3'd3
  } cmo_op_t;

  // one registered snoop event
  typedef struct packed {
    logic  valid;
    line_t line;
  } snoop_t;

endpackage : hwpf_pkg

/* pf_req_if.sv */
`timescale 1ns/10ps

// request and status of one stride engine toward the arbiter
interface pf_req_if;
  import hwpf_pkg::*;

  logic  req_valid;
  logic  req_ready;
  line_t req_line;  // held with req_valid until accepted
  logic  busy;      // sequence running
  logic  enabled;   // base enable bit

  modport engine (
    output req_valid,
    output req_line,
    output busy,
    output enabled,
    input  req_ready
  );

  modport arb (
    input  req_valid,
    input  req_line,
    input  busy,
    input  enabled,
    output req_ready
  );

endinterface : pf_req_if

/* hwpf_snoop_mux.sv */
`timescale 1ns/10ps

module hwpf_snoop_mux (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           ld_valid_i,
  input  logic                                           ld_ready_i,
  input  hwpf_pkg::word_t                                ld_addr_i,
  input  logic                                           st_valid_i,
  input  logic                                           st_ready_i,
  input  hwpf_pkg::word_t                                st_addr_i,
  input  logic                                           cmo_valid_i,
  input  logic                                           cmo_ready_i,
  input  hwpf_pkg::cmo_op_t                              cmo_op_i,
  input  hwpf_pkg::word_t                                cmo_addr_i,
  output hwpf_pkg::snoop_t [hwpf_pkg::NR_SNOOP_PORTS-1:0] snoop_o
);
  import hwpf_pkg::*;

  logic  [NR_SNOOP_PORTS-1:0] hit;
  line_t                      line_d [NR_SNOOP_PORTS];
  logic  [NR_SNOOP_PORTS-1:0] valid_q;
  line_t                      line_q [NR_SNOOP_PORTS];

  // accepted requests only
  assign hit[0] = ld_valid_i & ld_ready_i;
  assign hit[1] = st_valid_i & st_ready_i;
  assign hit[2] = cmo_valid_i & cmo_ready_i & (cmo_op_i == CMO_PREFETCH);  // only prefetch cmo

  assign line_d[0] = ld_addr_i[$bits(word_t)-1:LINE_OFFSET_W];
  assign line_d[1] = st_addr_i[$bits(word_t)-1:LINE_OFFSET_W];
  assign line_d[2] = cmo_addr_i[$bits(word_t)-1:LINE_OFFSET_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= hit;  // one-cycle event
    end
  end

  // line captured only with an event
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NR_SNOOP_PORTS; p++) begin
      if (hit[p]) begin
        line_q[p] <= line_d[p];
      end
    end
  end

  for (genvar p = 0; p < NR_SNOOP_PORTS; p++) begin : gen_snoop_out
    assign snoop_o[p].valid = valid_q[p];
    assign snoop_o[p].line  = line_q[p];

    // requester address must be known at the handshake that made the event
    a_snoop_line_known: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      snoop_o[p].valid |-> !$isunknown(snoop_o[p].line))
    else $error("snoop port %0d: unknown line address", p);
  end

endmodule : hwpf_snoop_mux

/* hwpf_stride_engine.sv */
`timescale 1ns/10ps

module hwpf_stride_engine (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           base_set_i,
  input  hwpf_pkg::word_t                                base_i,
  output hwpf_pkg::word_t                                base_o,
  input  logic                                           param_set_i,
  input  hwpf_pkg::word_t                                param_i,
  output hwpf_pkg::word_t                                param_o,
  input  hwpf_pkg::snoop_t [hwpf_pkg::NR_SNOOP_PORTS-1:0] snoop_i,
  pf_req_if.engine                                       pf
);
  import hwpf_pkg::*;

  word_t               base_q;
  word_t               param_q;
  logic                busy_q;
  logic [NLINES_W-1:0] left_q;    // requests still to issue
  line_t               line_q;    // line of the pending request

  line_t               base_line;
  line_t               stride;
  logic [NLINES_W-1:0] nlines;
  logic                enabled;
  logic                rearm;
  logic                snoop_hit;
  logic                cfg_write;
  logic                start;
  logic                accept;
  logic                seq_done;

  assign base_line = base_q[$bits(word_t)-1:LINE_OFFSET_W];
  assign stride    = line_t'(param_q[STRIDE_LSB +: STRIDE_W]);  // unsigned stride in lines
  assign nlines    = param_q[NLINES_LSB +: NLINES_W];
  assign enabled   = base_q[BASE_EN_BIT];
  assign rearm     = base_q[BASE_REARM_BIT];

  // any snoop channel touching the base line
  always_comb begin
    snoop_hit = 1'b0;
    for (int p = 0; p < NR_SNOOP_PORTS; p++) begin
      if (snoop_i[p].valid && (snoop_i[p].line == base_line)) begin
        snoop_hit = 1'b1;
      end
    end
  end

  assign cfg_write = base_set_i | param_set_i;
  assign start     = enabled & ~busy_q & snoop_hit & ~cfg_write;
  assign accept    = pf.req_valid & pf.req_ready;
  // zero lines ends right at the trigger
  assign seq_done  = (start && (nlines == '0)) ||
                     (accept && (left_q == NLINES_W'(1)) && !cfg_write);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q  <= '0;
      param_q <= '0;
      busy_q  <= 1'b0;
      left_q  <= '0;
    end else begin
      if (param_set_i) begin
        param_q <= param_i;
      end
      if (cfg_write) begin
        busy_q <= 1'b0;  // abort running sequence
        if (base_set_i) begin
          base_q <= base_i;
        end
      end else if (seq_done) begin
        busy_q <= 1'b0;
        if (rearm) begin
          if (busy_q) begin
            base_q[$bits(word_t)-1:LINE_OFFSET_W] <= line_q;  // follow last requested line
          end
        end else begin
          base_q[BASE_EN_BIT] <= 1'b0;  // one-shot
        end
      end else if (start) begin
        busy_q <= 1'b1;
        left_q <= nlines;
      end else if (accept) begin
        left_q <= left_q - NLINES_W'(1);
      end
    end
  end

  // next line to request
  always_ff @(posedge clk_i) begin
    if (start) begin
      line_q <= base_line + stride;
    end else if (accept) begin
      line_q <= line_q + stride;
    end
  end

  assign pf.req_valid = busy_q;
  assign pf.req_line  = line_q;
  assign pf.busy      = busy_q;
  assign pf.enabled   = enabled;

  assign base_o  = base_q;
  assign param_o = param_q;

  // only a config write may withdraw an offered request
  a_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pf.req_valid && !pf.req_ready && !cfg_write |=>
      pf.req_valid && $stable(pf.req_line))
  else $error("prefetch request dropped or changed before acceptance");

endmodule : hwpf_stride_engine

/* hwpf_req_arbiter.sv */
`timescale 1ns/10ps

module hwpf_req_arbiter #(
  parameter int NrHwPrefetchers = 2
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  pf_req_if.arb                                                  pf [NrHwPrefetchers],
  output logic                                                   pf_req_valid_o,
  input  logic                                                   pf_req_ready_i,
  output hwpf_pkg::word_t                                        pf_req_addr_o,
  output logic [$clog2(NrHwPrefetchers > 1 ? NrHwPrefetchers : 2)-1:0] pf_req_sid_o,
  output hwpf_pkg::word_t                                        hwpf_status_o
);
  import hwpf_pkg::*;

  localparam int SidW = $clog2(NrHwPrefetchers > 1 ? NrHwPrefetchers : 2);

  logic [NrHwPrefetchers-1:0] req_v;
  logic [NrHwPrefetchers-1:0] busy_v;
  logic [NrHwPrefetchers-1:0] en_v;
  line_t                      line_v [NrHwPrefetchers];

  logic [SidW-1:0] ptr_q;       // last accepted engine
  logic            lock_q;      // output offered but not taken
  logic [SidW-1:0] lock_sel_q;
  logic [SidW-1:0] sel;
  logic            found;
  logic            accept;
  int              idx;

  if (NrHwPrefetchers < 1 || NrHwPrefetchers > MAX_ENGINES) begin : gen_bad_count
    $error("NrHwPrefetchers must be within 1..%0d", MAX_ENGINES);
  end

  for (genvar i = 0; i < NrHwPrefetchers; i++) begin : gen_unpack
    assign req_v[i]        = pf[i].req_valid;
    assign busy_v[i]       = pf[i].busy;
    assign en_v[i]         = pf[i].enabled;
    assign line_v[i]       = pf[i].req_line;
    assign pf[i].req_ready = pf_req_ready_i & found & (sel == SidW'(i));
  end

  // round robin starting after the last winner
  always_comb begin
    sel   = ptr_q;
    found = 1'b0;
    idx   = 0;
    if (lock_q) begin
      sel   = lock_sel_q;  // keep offer stable
      found = req_v[lock_sel_q];
    end else begin
      for (int k = 1; k <= NrHwPrefetchers; k++) begin
        idx = (int'(ptr_q) + k) % NrHwPrefetchers;
        if (!found && req_v[idx]) begin
          sel   = SidW'(idx);
          found = 1'b1;
        end
      end
    end
  end

  assign accept = found & pf_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q      <= SidW'(NrHwPrefetchers - 1);  // engine 0 goes first
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      lock_q     <= found & ~pf_req_ready_i;
      lock_sel_q <= sel;
      if (accept) begin
        ptr_q <= sel;
      end
    end
  end

  assign pf_req_valid_o = found;
  assign pf_req_addr_o  = {line_v[sel], {LINE_OFFSET_W{1'b0}}};
  assign pf_req_sid_o   = sel;

  // busy in the low half, enable in the high half
  always_comb begin
    hwpf_status_o = '0;
    for (int i = 0; i < NrHwPrefetchers; i++) begin
      hwpf_status_o[i]               = busy_v[i];
      hwpf_status_o[MAX_ENGINES + i] = en_v[i];
    end
  end

  // engine holds its request and the lock holds the grant
  a_stable_under_backpressure: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pf_req_valid_o && !pf_req_ready_i |=>
      pf_req_valid_o && $stable(pf_req_addr_o) && $stable(pf_req_sid_o))
  else $error("prefetch request changed before acceptance");

endmodule : hwpf_req_arbiter

/* hwpf_subsystem.sv */
`timescale 1ns/10ps

module hwpf_subsystem #(
  parameter int NrHwPrefetchers = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // observed requester channels
  input  logic                                     ld_valid_i,
  input  logic                                     ld_ready_i,
  input  hwpf_pkg::word_t                          ld_addr_i,
  input  logic                                     st_valid_i,
  input  logic                                     st_ready_i,
  input  hwpf_pkg::word_t                          st_addr_i,
  input  logic                                     cmo_valid_i,
  input  logic                                     cmo_ready_i,
  input  hwpf_pkg::cmo_op_t                        cmo_op_i,
  input  hwpf_pkg::word_t                          cmo_addr_i,
  // per-engine configuration
  input  logic            [NrHwPrefetchers-1:0]    hwpf_base_set_i,
  input  hwpf_pkg::word_t [NrHwPrefetchers-1:0]    hwpf_base_i,
  output hwpf_pkg::word_t [NrHwPrefetchers-1:0]    hwpf_base_o,
  input  logic            [NrHwPrefetchers-1:0]    hwpf_param_set_i,
  input  hwpf_pkg::word_t [NrHwPrefetchers-1:0]    hwpf_param_i,
  output hwpf_pkg::word_t [NrHwPrefetchers-1:0]    hwpf_param_o,
  // merged prefetch requests toward the cache
  output logic                                     pf_req_valid_o,
  input  logic                                     pf_req_ready_i,
  output hwpf_pkg::word_t                          pf_req_addr_o,
  output logic [$clog2(NrHwPrefetchers > 1 ? NrHwPrefetchers : 2)-1:0] pf_req_sid_o,
  output hwpf_pkg::word_t                          hwpf_status_o
);
  import hwpf_pkg::*;

  snoop_t [NR_SNOOP_PORTS-1:0] snoop;  // shared by all engines

  pf_req_if pf_if [NrHwPrefetchers] ();

  hwpf_snoop_mux i_snoop_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ld_valid_i  (ld_valid_i),
    .ld_ready_i  (ld_ready_i),
    .ld_addr_i   (ld_addr_i),
    .st_valid_i  (st_valid_i),
    .st_ready_i  (st_ready_i),
    .st_addr_i   (st_addr_i),
    .cmo_valid_i (cmo_valid_i),
    .cmo_ready_i (cmo_ready_i),
    .cmo_op_i    (cmo_op_i),
    .cmo_addr_i  (cmo_addr_i),
    .snoop_o     (snoop)
  );

  for (genvar h = 0; h < NrHwPrefetchers; h++) begin : gen_engine
    hwpf_stride_engine i_engine (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .base_set_i  (hwpf_base_set_i[h]),
      .base_i      (hwpf_base_i[h]),
      .base_o      (hwpf_base_o[h]),
      .param_set_i (hwpf_param_set_i[h]),
      .param_i     (hwpf_param_i[h]),
      .param_o     (hwpf_param_o[h]),
      .snoop_i     (snoop),
      .pf          (pf_if[h])
    );
  end

  hwpf_req_arbiter #(
    .NrHwPrefetchers (NrHwPrefetchers)
  ) i_req_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pf             (pf_if),
    .pf_req_valid_o (pf_req_valid_o),
    .pf_req_ready_i (pf_req_ready_i),
    .pf_req_addr_o  (pf_req_addr_o),
    .pf_req_sid_o   (pf_req_sid_o),
    .hwpf_status_o  (hwpf_status_o)
  );

endmodule : hwpf_subsystem

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int HalfPeriod  = 10,  // 20 ns clock
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;  // released on a clock edge
  end

endmodule : tb_clk_gen

/* tb_hwpf_subsystem.sv */
`timescale 1ns/10ps

module tb_hwpf_subsystem;
  import hwpf_pkg::*;

  localparam int NrEng     = 2;
  localparam int DriveDly  = 2;
  localparam int IdleLimit = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   ld_valid, ld_ready, st_valid, st_ready, cmo_valid, cmo_ready;
  word_t                  ld_addr, st_addr, cmo_addr;
  cmo_op_t                cmo_op;
  logic  [NrEng-1:0]      base_set, param_set;
  word_t [NrEng-1:0]      base_in, param_in, base_out, param_out;
  logic                   pf_req_valid, pf_req_ready;
  word_t                  pf_req_addr, hwpf_status;
  logic  [0:0]            pf_req_sid;

  // reference model state
  word_t                      m_base    [NrEng];
  word_t                      m_param   [NrEng];
  line_t                      exp_line  [NrEng];  // next line each engine must request
  int                         exp_left  [NrEng];
  logic [NR_SNOOP_PORTS-1:0]  trig_v;
  line_t                      trig_line [NR_SNOOP_PORTS];
  logic [0:0]                 last_sid;
  logic                       other_pend;  // other engine waiting at last accept
  word_t                      prev_addr;
  logic [0:0]                 prev_sid;

  string  test_name;
  integer seed;
  integer rnd;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  hwpf_subsystem #(.NrHwPrefetchers(NrEng)) dut0 (
    .clk_i (clk), .rst_ni (rst_n),
    .ld_valid_i (ld_valid), .ld_ready_i (ld_ready), .ld_addr_i (ld_addr),
    .st_valid_i (st_valid), .st_ready_i (st_ready), .st_addr_i (st_addr),
    .cmo_valid_i (cmo_valid), .cmo_ready_i (cmo_ready),
    .cmo_op_i (cmo_op), .cmo_addr_i (cmo_addr),
    .hwpf_base_set_i (base_set), .hwpf_base_i (base_in), .hwpf_base_o (base_out),
    .hwpf_param_set_i (param_set), .hwpf_param_i (param_in), .hwpf_param_o (param_out),
    .pf_req_valid_o (pf_req_valid), .pf_req_ready_i (pf_req_ready),
    .pf_req_addr_o (pf_req_addr), .pf_req_sid_o (pf_req_sid),
    .hwpf_status_o (hwpf_status)
  );

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic word_t base_word(line_t ln, logic rearm);
    word_t w;
    w = {ln, {LINE_OFFSET_W{1'b0}}};
    w[BASE_EN_BIT]    = 1'b1;
    w[BASE_REARM_BIT] = rearm;
    return w;
  endfunction

  function automatic word_t param_word(int stride, int nlines);
    word_t w;
    w = '0;
    w[STRIDE_LSB +: STRIDE_W] = STRIDE_W'(stride);
    w[NLINES_LSB +: NLINES_W] = NLINES_W'(nlines);
    return w;
  endfunction

  function automatic line_t stride_of(int i);
    return line_t'(m_param[i][STRIDE_LSB +: STRIDE_W]);
  endfunction

  function automatic logic trig_hit(line_t ln);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < NR_SNOOP_PORTS; p++) begin
      if (trig_v[p] && trig_line[p] == ln) hit = 1'b1;
    end
    return hit;
  endfunction

  // reference model of the snoop stage and the engines
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NrEng; i++) begin
        m_base[i]   <= '0;
        m_param[i]  <= '0;
        exp_line[i] <= '0;
        exp_left[i] <= 0;
      end
      trig_v     <= '0;
      last_sid   <= '0;
      other_pend <= 1'b0;
    end else begin
      trig_v[0]    <= ld_valid & ld_ready;
      trig_v[1]    <= st_valid & st_ready;
      trig_v[2]    <= cmo_valid & cmo_ready & (cmo_op == CMO_PREFETCH);
      trig_line[0] <= ld_addr[63:LINE_OFFSET_W];
      trig_line[1] <= st_addr[63:LINE_OFFSET_W];
      trig_line[2] <= cmo_addr[63:LINE_OFFSET_W];
      for (int i = 0; i < NrEng; i++) begin
        if (base_set[i] || param_set[i]) begin
          if (base_set[i]) m_base[i] <= base_in[i];
          if (param_set[i]) m_param[i] <= param_in[i];
          exp_left[i] <= 0;
        end else if (exp_left[i] == 0) begin
          if (m_base[i][BASE_EN_BIT] && trig_hit(m_base[i][63:LINE_OFFSET_W])) begin
            exp_line[i] <= m_base[i][63:LINE_OFFSET_W] + stride_of(i);
            exp_left[i] <= int'(m_param[i][NLINES_LSB +: NLINES_W]);
            // empty sequence ends at the trigger
            if (m_param[i][NLINES_LSB +: NLINES_W] == '0 && !m_base[i][BASE_REARM_BIT])
              m_base[i][BASE_EN_BIT] <= 1'b0;
          end
        end else if (pf_req_valid && pf_req_ready && pf_req_sid == i) begin
          exp_line[i] <= exp_line[i] + stride_of(i);
          exp_left[i] <= exp_left[i] - 1;
          if (exp_left[i] == 1) begin
            if (m_base[i][BASE_REARM_BIT]) m_base[i][63:LINE_OFFSET_W] <= exp_line[i];
            else m_base[i][BASE_EN_BIT] <= 1'b0;
          end
        end
      end
      if (pf_req_valid && pf_req_ready) begin
        last_sid   <= pf_req_sid;
        other_pend <= (exp_left[NrEng - 1 - int'(pf_req_sid)] != 0);
      end
      prev_addr <= pf_req_addr;
      prev_sid  <= pf_req_sid;
    end
  end

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    !pf_req_valid && hwpf_status == '0 && base_out == '0 && param_out == '0)
  else begin
    $display("error %s reset expected valid 0 status 0 base 0 param 0 %s %0b %h %h %h",
             test_name, "actual valid/status/base/param", $sampled(pf_req_valid),
             $sampled(hwpf_status), $sampled(base_out), $sampled(param_out));
    abort_run();
  end

  a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
    pf_req_valid && pf_req_ready |->
      pf_req_addr == {exp_line[pf_req_sid], {LINE_OFFSET_W{1'b0}}})
  else begin
    $display("error %s addr sid %0d expected %h actual %h", test_name, $sampled(pf_req_sid),
             {$sampled(exp_line[pf_req_sid]), 6'h0}, $sampled(pf_req_addr));
    abort_run();
  end

  // also catches filtered cmo ops and unaccepted handshakes
  a_no_extra_req: assert property (@(posedge clk) disable iff (!rst_n)
    pf_req_valid |-> exp_left[pf_req_sid] != 0)
  else begin
    $display("error %s sid %0d expected no request actual %h", test_name,
             $sampled(pf_req_sid), $sampled(pf_req_addr));
    abort_run();
  end

  a_held_req: assert property (@(posedge clk) disable iff (!rst_n)
    pf_req_valid && !pf_req_ready |=>
      pf_req_valid && pf_req_addr == prev_addr && pf_req_sid == prev_sid)
  else begin
    $display("error %s held request expected %h/%0d actual %h/%0d", test_name,
             $sampled(prev_addr), $sampled(prev_sid), $sampled(pf_req_addr),
             $sampled(pf_req_sid));
    abort_run();
  end

  a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
    pf_req_valid && pf_req_ready && other_pend |-> pf_req_sid != last_sid)
  else begin
    $display("error %s round robin expected sid %0d actual %0d", test_name,
             ~$sampled(last_sid), $sampled(pf_req_sid));
    abort_run();
  end

  for (genvar i = 0; i < NrEng; i++) begin : gen_eng_chk
    a_base_rb: assert property (@(posedge clk) disable iff (!rst_n)
      base_out[i] == m_base[i])
    else begin
      $display("error %s base[%0d] expected %h actual %h", test_name, i,
               $sampled(m_base[i]), $sampled(base_out[i]));
      abort_run();
    end

    a_param_rb: assert property (@(posedge clk) disable iff (!rst_n)
      param_out[i] == m_param[i])
    else begin
      $display("error %s param[%0d] expected %h actual %h", test_name, i,
               $sampled(m_param[i]), $sampled(param_out[i]));
      abort_run();
    end

    a_busy_bit: assert property (@(posedge clk) disable iff (!rst_n)
      hwpf_status[i] == (exp_left[i] != 0))
    else begin
      $display("error %s busy[%0d] expected %0b actual %0b", test_name, i,
               $sampled(exp_left[i]) != 0, $sampled(hwpf_status[i]));
      abort_run();
    end

    a_enable_bit: assert property (@(posedge clk) disable iff (!rst_n)
      hwpf_status[MAX_ENGINES + i] == m_base[i][BASE_EN_BIT])
    else begin
      $display("error %s enable[%0d] expected %0b actual %0b", test_name, i,
               $sampled(m_base[i][BASE_EN_BIT]), $sampled(hwpf_status[MAX_ENGINES + i]));
      abort_run();
    end
  end

  // random back-pressure toward the cache
  initial begin
    seed         = 32'h7d27ba24;
    pf_req_ready = 1'b0;
    forever begin
      @(posedge clk);
      #(DriveDly);
      rnd          = $random(seed);
      pf_req_ready = rnd[0];
    end
  end

  task automatic step();
    @(posedge clk);
    #(DriveDly);
  endtask

  task automatic write_cfg(int eng, word_t base, word_t param);
    step();
    base_set[eng]  = 1'b1;
    base_in[eng]   = base;
    param_set[eng] = 1'b1;
    param_in[eng]  = param;
    step();
    base_set  = '0;
    param_set = '0;
  endtask

  // ch 0 load, 1 store, 2 cmo
  task automatic send_req(int ch, word_t addr, cmo_op_t op, logic rdy);
    step();
    case (ch)
      0: begin
        ld_valid = 1'b1;
        ld_ready = rdy;
        ld_addr  = addr;
      end
      1: begin
        st_valid = 1'b1;
        st_ready = rdy;
        st_addr  = addr;
      end
      default: begin
        cmo_valid = 1'b1;
        cmo_ready = rdy;
        cmo_op    = op;
        cmo_addr  = addr;
      end
    endcase
    step();
    ld_valid  = 1'b0;
    ld_ready  = 1'b0;
    st_valid  = 1'b0;
    st_ready  = 1'b0;
    cmo_valid = 1'b0;
    cmo_ready = 1'b0;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n >= 50) begin
        $display("timeout: reset was never released");
        abort_run();
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    repeat (2) @(posedge clk);  // engine turns busy one edge after the handshake
    while (hwpf_status[NrEng-1:0] != '0 || pf_req_valid) begin
      if (n >= IdleLimit) begin
        $display("timeout: engines still busy in test %s", test_name);
        abort_run();
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic hold_quiet(int cycles);
    int n;
    n = 0;
    while (n < cycles) begin
      @(posedge clk);
      n++;
    end
  endtask

  initial begin
    test_name = "reset";
    ld_valid  = 1'b0;
    ld_ready  = 1'b0;
    ld_addr   = '0;
    st_valid  = 1'b0;
    st_ready  = 1'b0;
    st_addr   = '0;
    cmo_valid = 1'b0;
    cmo_ready = 1'b0;
    cmo_op    = CMO_PREFETCH;
    cmo_addr  = '0;
    base_set  = '0;
    base_in   = '0;
    param_set = '0;
    param_in  = '0;
    wait_reset();

    test_name = "ld_oneshot";
    write_cfg(0, base_word(58'h100, 1'b0), param_word(3, 4));
    send_req(0, {58'h100, 6'h18}, CMO_PREFETCH, 1'b1);
    wait_idle();

    test_name = "st_rearm";
    write_cfg(1, base_word(58'h2000, 1'b1), param_word(1, 3));
    send_req(1, {58'h2000, 6'h3f}, CMO_PREFETCH, 1'b1);
    wait_idle();
    send_req(1, {58'h2003, 6'h00}, CMO_PREFETCH, 1'b1);  // moved base line
    wait_idle();

    test_name = "cmo_filter";
    write_cfg(0, base_word(58'h300, 1'b0), param_word(2, 2));
    send_req(2, {58'h300, 6'h04}, CMO_INVAL, 1'b1);
    send_req(2, {58'h300, 6'h04}, CMO_FLUSH, 1'b1);
    send_req(2, {58'h300, 6'h04}, CMO_CLEAN, 1'b1);
    send_req(0, {58'h300, 6'h00}, CMO_PREFETCH, 1'b0);  // valid without ready
    send_req(1, {58'h300, 6'h00}, CMO_PREFETCH, 1'b0);
    send_req(2, {58'h300, 6'h00}, CMO_PREFETCH, 1'b0);
    hold_quiet(20);
    send_req(2, {58'h300, 6'h20}, CMO_PREFETCH, 1'b1);
    wait_idle();

    test_name = "both_busy";
    write_cfg(0, base_word(58'h4000, 1'b0), param_word(1, 6));
    write_cfg(1, base_word(58'h4000, 1'b1), param_word(7, 5));
    send_req(0, {58'h4000, 6'h08}, CMO_PREFETCH, 1'b1);
    wait_idle();

    test_name = "zero_lines";
    write_cfg(0, base_word(58'h500, 1'b0), param_word(4, 0));
    send_req(1, {58'h500, 6'h10}, CMO_PREFETCH, 1'b1);
    hold_quiet(10);

    $display("RESULT: PASS");
    $finish;
  end

endmodule : tb_hwpf_subsystem

/* tb.f */
hwpf_pkg.sv
pf_req_if.sv
hwpf_snoop_mux.sv
hwpf_stride_engine.sv
hwpf_req_arbiter.sv
hwpf_subsystem.sv
tb_clk_gen.sv
tb_hwpf_subsystem.sv
